// ==== verification/epd_testdata.txt ====
// Words 0-2: timing, {n_lut, op_frame, beats, frames, lut_frames}, op request
// Words 3-7: LUT {addr, data}; then beats {valid, vin, bi, exp_sd, exp_bo, 0}
010101002010103001
0504020503
400000203
054E4
0E41B
09C4E
0DC9C
009D8
// Init frames, output masked
100000C25082504250025000C250825042500250
1000080378027040900090080378027040900090
100000C25082504250025000C250825042500250
1000080378027040900090080378027040900090
// Normal frame, seq and auto decoding
100000C25082504250025E40C150815041500150
1000080378027040900094B80378027240924090
// Region update frame
13A6C803780270425002594803780271436143C0
1FFFF1C32183214321032D81C221822142210220
// Underrun on the first beat
000001C32183214321032001C321832143210320
100001C32183214321032001C321832143210320

// ==== files.f ====
logic/epd_pkg.sv
logic/scan_timing.sv
logic/op_sequencer.sv
logic/wvfm_lut.sv
logic/pixel_pipe.sv
logic/epd_ctrl.sv
verification/epd_checker.sv
verification/epd_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module epd_ctrl_tb \
    -f files.f -Mdir obj_dir -o epd_sim
./obj_dir/epd_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verification/epd_ctrl_tb.sv ====
`timescale 1ns/1ps

module epd_ctrl_tb
    import epd_pkg::*;
();

    // First beat record in the data file
    localparam int beat_base = 8;

    logic         clk;
    logic         rst;
    logic         vin_vsync;
    logic [15:0]  vin_pixel;
    logic         vin_valid;
    logic         vin_ready;
    logic [63:0]  bi_pixel;
    logic         bi_valid;
    logic         bi_ready;
    logic [63:0]  bo_pixel;
    logic         bo_valid;
    epd_timing_t  timing;
    lut_wr_t      lut_wr;
    op_req_t      op_req;
    logic [5:0]   lut_frames;
    logic         sys_ready;
    logic         global_en;
    logic         epd_gdclk;
    logic         epd_gdsp;
    logic         epd_sdclk;
    logic         epd_sdle;
    logic         epd_sdce0;
    logic [7:0]   epd_sd;
    logic [159:0] tdata [0:63];
    logic [7:0]   exp_sd;
    logic [63:0]  exp_bo;
    logic         exp_push;
    logic         test_end;
    logic         run_end;
    logic         loaded;
    int           test_id;
    int           n_frames;
    int           n_tests;
    int           n_failed;

    epd_ctrl #(
        .init_frames (2),
        .lut_depth_w (14)
    ) i_epd_ctrl (
        .clk (clk), .rst (rst), .vin_vsync (vin_vsync), .vin_pixel (vin_pixel),
        .vin_valid (vin_valid), .vin_ready (vin_ready), .bi_pixel (bi_pixel),
        .bi_valid (bi_valid), .bi_ready (bi_ready), .bo_pixel (bo_pixel),
        .bo_valid (bo_valid), .timing (timing), .lut_wr (lut_wr), .op_req (op_req),
        .lut_frames (lut_frames), .sys_ready (sys_ready), .global_en (global_en),
        .epd_gdclk (epd_gdclk), .epd_gdsp (epd_gdsp), .epd_sdclk (epd_sdclk),
        .epd_sdle (epd_sdle), .epd_sdce0 (epd_sdce0), .epd_sd (epd_sd)
    );

    epd_checker i_epd_checker (
        .clk (clk), .rst (rst), .global_en (global_en), .vin_ready (vin_ready),
        .bi_ready (bi_ready), .bo_valid (bo_valid), .epd_sdce0 (epd_sdce0),
        .epd_gdsp (epd_gdsp), .epd_sdle (epd_sdle), .epd_gdclk (epd_gdclk),
        .epd_sdclk (epd_sdclk), .epd_sd (epd_sd), .bo_pixel (bo_pixel), .timing (timing),
        .exp_push (exp_push), .exp_sd (exp_sd), .exp_bo (exp_bo), .test_end (test_end),
        .run_end (run_end), .test_id (test_id), .n_frames (n_frames),
        .n_tests (n_tests), .n_failed (n_failed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Inputs move 5 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic close_test();
        test_end = 1'b1;
        step();
        test_end = 1'b0;
        test_id++;
    endtask

    task automatic run_frame(input int f, input int beats);
        logic [159:0] rec;
        int           gap;
        gap = $urandom % 8;
        repeat (8 + gap) step();
        vin_vsync = 1'b1;
        step();
        vin_vsync = 1'b0;
        for (int b = 0; b < beats; b++) begin
            rec = tdata[beat_base + f * beats + b];
            while (!vin_ready) step();
            // Data goes out on the cycle after ready
            step();
            vin_valid = rec[156];
            bi_valid  = rec[156];
            vin_pixel = rec[155:140];
            bi_pixel  = rec[139:76];
            exp_sd    = rec[75:68];
            exp_bo    = rec[67:4];
            exp_push  = 1'b1;
            step();
            vin_valid = 1'b0;
            bi_valid  = 1'b0;
            exp_push  = 1'b0;
        end
        repeat (4) step();
        close_test();
    endtask

    initial begin
        int beats;
        int op_frame;
        int n_lut;
        rst = 1'b1;
        vin_vsync = 1'b0;
        vin_pixel = '0;
        vin_valid = 1'b0;
        bi_pixel = '0;
        bi_valid = 1'b0;
        timing = '0;
        lut_wr = '0;
        op_req = '0;
        lut_frames = '0;
        sys_ready = 1'b0;
        global_en = 1'b0;
        exp_sd = '0;
        exp_bo = '0;
        exp_push = 1'b0;
        test_end = 1'b0;
        run_end = 1'b0;
        loaded = 1'b0;
        test_id = 1;
        void'($urandom(99581));
        $readmemh("verification/epd_testdata.txt", tdata);
        timing = tdata[0][71:0];
        lut_frames = tdata[1][5:0];
        n_frames = int'(tdata[1][15:8]);
        beats = int'(tdata[1][23:16]);
        op_frame = int'(tdata[1][31:24]);
        n_lut = int'(tdata[1][39:32]);
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;

        // Disabled controller ignores vsync
        sys_ready = 1'b1;
        repeat (4) step();
        vin_vsync = 1'b1;
        step();
        vin_vsync = 1'b0;
        repeat (16) step();
        close_test();

        for (int i = 0; i < n_lut; i++) begin
            lut_wr.we   = 1'b1;
            lut_wr.addr = tdata[3 + i][19:8];
            lut_wr.data = tdata[3 + i][7:0];
            step();
        end
        lut_wr.we = 1'b0;
        global_en = 1'b1;

        for (int f = 0; f < n_frames; f++) begin
            if (f + 1 == op_frame) begin
                op_req = tdata[2][56:0];
                op_req.en = 1'b1;
                step();
                op_req.en = 1'b0;
            end
            run_frame(f, beats);
        end

        run_end = 1'b1;
        step();
        run_end = 1'b0;
        step();
        $display("%0d tests run, %0d failed", n_tests, n_failed);
        if (n_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the frame count and the frame length
    initial begin
        int limit;
        int vtot;
        int htot;
        wait (loaded);
        vtot = timing.vfp + timing.vsync + timing.vbp + timing.vact;
        htot = timing.hfp + timing.hsync + timing.hbp + timing.hact;
        limit = 100 + (n_frames + 2) * (vtot * htot + 32);
        #(limit * 40);
        $display("watchdog expired after %0d cycles, run did not finish", limit);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== verification/epd_checker.sv ====
`timescale 1ns/1ps

module epd_checker
    import epd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        global_en,
    input  logic        vin_ready,
    input  logic        bi_ready,
    input  logic        bo_valid,
    input  logic        epd_sdce0,
    input  logic        epd_gdsp,
    input  logic        epd_sdle,
    input  logic        epd_gdclk,
    input  logic        epd_sdclk,
    input  logic [7:0]  epd_sd,
    input  logic [63:0] bo_pixel,
    input  epd_timing_t timing,
    input  logic        exp_push,
    input  logic [7:0]  exp_sd,
    input  logic [63:0] exp_bo,
    input  logic        test_end,
    input  logic        run_end,
    input  int          test_id,
    input  int          n_frames,
    output int          n_tests,
    output int          n_failed
);

    logic [71:0] exp_q [$];
    int          errors = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          sdce_low = 0;
    int          sdle_high = 0;
    int          gdclk_high = 0;
    int          sdclk_high = 0;

    assign n_tests  = tests_run;
    assign n_failed = tests_bad;

    task automatic report(input int id);
        tests_run++;
        if (errors == 0) begin
            $display("test %0d passed", id);
        end else begin
            $display("test %0d failed with %0d errors", id, errors);
            tests_bad++;
        end
        errors = 0;
    endtask

    always @(posedge clk) begin
        logic [71:0] e;
        int          vtot;
        int          want_ce;
        int          want_le;
        int          want_gd;
        int          want_sc;
        if (!rst) begin
            if (!global_en &&
                    (vin_ready || bi_ready || bo_valid || !epd_sdce0 || !epd_gdsp)) begin
                $display("Fail at %0t: strobes active while global_en is low", $time);
                errors++;
            end
            // Both input streams share one ready
            if (bi_ready !== vin_ready) begin
                $display("Fail at %0t: bi_ready %b, expected vin_ready %b",
                    $time, bi_ready, vin_ready);
                errors++;
            end
            if (!epd_sdce0) sdce_low++;
            if (epd_sdle) sdle_high++;
            if (epd_gdclk) gdclk_high++;
            if (epd_sdclk) sdclk_high++;
            if (bo_valid) begin
                if (exp_q.size() == 0) begin
                    $display("output beat at %0t arrived with no beat expected", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (epd_sd !== e[71:64] || bo_pixel !== e[63:0]) begin
                        $display("Fail at %0t: epd_sd %h bo_pixel %h, expected %h %h",
                            $time, epd_sd, bo_pixel, e[71:64], e[63:0]);
                        errors++;
                    end
                end
            end
            if (exp_push) exp_q.push_back({exp_sd, exp_bo});
            if (test_end) begin
                if (exp_q.size() != 0) begin
                    $display("test %0d ended with %0d beats never output", test_id,
                        exp_q.size());
                    errors++;
                    exp_q.delete();
                end
                report(test_id);
            end
            if (run_end) begin
                // Strobe totals over all frames
                vtot = timing.vfp + timing.vsync + timing.vbp + timing.vact;
                want_ce = n_frames * timing.vact * timing.hact;
                want_le = n_frames * timing.hsync * vtot;
                want_gd = n_frames * vtot * (timing.hsync + timing.hbp + timing.hact);
                want_sc = n_frames * vtot * (timing.hfp + timing.hsync + timing.hact);
                if (sdce_low != want_ce) begin
                    $display("Fail at %0t: %0d epd_sdce0 beats, expected %0d",
                        $time, sdce_low, want_ce);
                    errors++;
                end
                if (sdle_high != want_le) begin
                    $display("Fail at %0t: %0d epd_sdle cycles, expected %0d",
                        $time, sdle_high, want_le);
                    errors++;
                end
                if (gdclk_high != want_gd) begin
                    $display("Fail at %0t: %0d epd_gdclk cycles, expected %0d",
                        $time, gdclk_high, want_gd);
                    errors++;
                end
                if (sdclk_high != want_sc) begin
                    $display("Fail at %0t: %0d epd_sdclk cycles, expected %0d",
                        $time, sdclk_high, want_sc);
                    errors++;
                end
                report(test_id);
            end
        end
    end

endmodule

// ==== logic/epd_ctrl.sv ====
`timescale 1ns/1ps

module epd_ctrl
    import epd_pkg::*;
#(
    parameter int init_frames = 2,
    parameter int lut_depth_w = 14
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        vin_vsync,
    input  logic [15:0] vin_pixel,
    input  logic        vin_valid,
    output logic        vin_ready,
    input  logic [63:0] bi_pixel,
    input  logic        bi_valid,
    output logic        bi_ready,
    output logic [63:0] bo_pixel,
    output logic        bo_valid,
    input  epd_timing_t timing,
    input  lut_wr_t     lut_wr,
    input  op_req_t     op_req,
    input  logic [5:0]  lut_frames,
    input  logic        sys_ready,
    input  logic        global_en,
    output logic        epd_gdclk,
    output logic        epd_gdsp,
    output logic        epd_sdclk,
    output logic        epd_sdle,
    output logic        epd_sdce0,
    output logic [7:0]  epd_sd
);

    logic                         fetch;
    logic                         frame_start;
    logic [12:0]                  h_pix;
    logic [11:0]                  v_line;
    logic                         frame_valid;
    logic [pix_per_clk-1:0]       in_region;
    logic [5:0]                   auto_fcnt;
    logic                         init_active;
    lut_addr_t [pix_per_clk-1:0]  rd_addr;
    logic [2*pix_per_clk-1:0]     rd_code;

    // Both FIFOs are read in the same cycle
    assign vin_ready = fetch;
    assign bi_ready  = fetch;

    scan_timing i_scan_timing (
        .clk         (clk),
        .rst         (rst),
        .timing      (timing),
        .vin_vsync   (vin_vsync),
        .sys_ready   (sys_ready),
        .global_en   (global_en),
        .vin_valid   (vin_valid),
        .bi_valid    (bi_valid),
        .fetch       (fetch),
        .frame_start (frame_start),
        .h_pix       (h_pix),
        .v_line      (v_line),
        .frame_valid (frame_valid),
        .epd_gdclk   (epd_gdclk),
        .epd_gdsp    (epd_gdsp),
        .epd_sdclk   (epd_sdclk),
        .epd_sdle    (epd_sdle),
        .epd_sdce0   (epd_sdce0)
    );

    op_sequencer #(
        .init_frames (init_frames)
    ) i_op_sequencer (
        .clk         (clk),
        .rst         (rst),
        .op_req      (op_req),
        .lut_frames  (lut_frames),
        .frame_start (frame_start),
        .h_pix       (h_pix),
        .v_line      (v_line),
        .in_region   (in_region),
        .auto_fcnt   (auto_fcnt),
        .init_active (init_active)
    );

    wvfm_lut #(
        .lut_depth_w (lut_depth_w)
    ) i_wvfm_lut (
        .clk     (clk),
        .lut_wr  (lut_wr),
        .rd_addr (rd_addr),
        .rd_code (rd_code)
    );

    pixel_pipe i_pixel_pipe (
        .clk         (clk),
        .rst         (rst),
        .fetch       (fetch),
        .frame_valid (frame_valid),
        .vin_pixel   (vin_pixel),
        .bi_pixel    (bi_pixel),
        .in_region   (in_region),
        .auto_fcnt   (auto_fcnt),
        .lut_frames  (lut_frames),
        .init_active (init_active),
        .rd_code     (rd_code),
        .rd_addr     (rd_addr),
        .epd_sd      (epd_sd),
        .bo_pixel    (bo_pixel),
        .bo_valid    (bo_valid)
    );

endmodule

// ==== logic/pixel_pipe.sv ====
`timescale 1ns/1ps

module pixel_pipe
    import epd_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch,
    input  logic                         frame_valid,
    input  logic [15:0]                  vin_pixel,
    input  logic [63:0]                  bi_pixel,
    input  logic [pix_per_clk-1:0]       in_region,
    input  logic [5:0]                   auto_fcnt,
    input  logic [5:0]                   lut_frames,
    input  logic                         init_active,
    input  logic [2*pix_per_clk-1:0]     rd_code,
    output lut_addr_t [pix_per_clk-1:0]  rd_addr,
    output logic [7:0]                   epd_sd,
    output logic [63:0]                  bo_pixel,
    output logic                         bo_valid
);

    logic                   s1_active;
    logic                   s2_active;
    logic [pix_per_clk-1:0] s1_region;
    logic [63:0]            new_word;
    logic [63:0]            s2_bi;
    logic [63:0]            s2_new;
    logic                   kill;

    // Data lags fetch by one clock, so the region flags are held one stage
    always_ff @(posedge clk) begin
        s1_region <= in_region;
    end

    for (genvar i = 0; i < pix_per_clk; i++) begin : g_lane
        state_word_u w_in;
        state_word_u w_out;
        logic [5:0]  fcnt;
        logic [5:0]  seq;
        logic [3:0]  src;

        assign w_in = bi_pixel[16*i +: 16];

        // Address decode differs between the two views
        assign fcnt = w_in.seq.auto ? auto_fcnt : w_in.seq.fcnt;
        assign src  = w_in.seq.auto ? w_in.auto.src : w_in.seq.src;
        assign seq  = lut_frames - fcnt;
        assign rd_addr[i] = '{seq: seq, tgt: w_in.seq.tgt, src: src};

        always_comb begin
            w_out = w_in;
            if (s1_region[i]) begin
                // Start a new transition towards the incoming pixel
                w_out.seq.auto   = 1'b0;
                w_out.seq.unused = 1'b0;
                w_out.seq.src    = w_in.seq.tgt;
                w_out.seq.fcnt   = lut_frames;
                w_out.seq.tgt    = vin_pixel[4*i +: 4];
            end else if (!w_in.seq.auto) begin
                if (w_in.seq.fcnt != 6'd0) begin
                    w_out.seq.fcnt = w_in.seq.fcnt - 6'd1;
                end else begin
                    w_out.seq.src = w_in.seq.tgt;
                end
            end
        end

        assign new_word[16*i +: 16] = w_out;
    end

    // Masked frames drive nothing and leave the framebuffer untouched
    assign kill = !frame_valid || init_active;

    always_ff @(posedge clk) begin
        s2_bi    <= bi_pixel;
        s2_new   <= new_word;
        bo_pixel <= kill ? s2_bi : s2_new;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_active <= 1'b0;
            s2_active <= 1'b0;
            bo_valid  <= 1'b0;
            epd_sd    <= '0;
        end else begin
            s1_active <= fetch;
            s2_active <= s1_active;
            bo_valid  <= s2_active;
            epd_sd    <= (s2_active && !kill) ? rd_code : '0;
        end
    end

    a_bo_valid_lag: assert property (@(posedge clk) disable iff (rst)
        bo_valid == $past(fetch, 3));

endmodule

// ==== logic/wvfm_lut.sv ====
`timescale 1ns/1ps

module wvfm_lut
    import epd_pkg::*;
#(
    parameter int lut_depth_w = 14
) (
    input  logic                         clk,
    input  lut_wr_t                      lut_wr,
    input  lut_addr_t [pix_per_clk-1:0]  rd_addr,
    output logic [2*pix_per_clk-1:0]     rd_code
);

    // Byte address width, each byte packs four 2-bit entries
    localparam int byte_w = lut_depth_w - 2;

    logic [7:0] mem [2**byte_w];

    always_ff @(posedge clk) begin
        if (lut_wr.we) begin
            mem[lut_wr.addr[byte_w-1:0]] <= lut_wr.data;
        end
    end

    // Four read ports, entry n of a byte sits in bits [2n+1:2n]
    always_ff @(posedge clk) begin
        for (int i = 0; i < pix_per_clk; i++) begin
            rd_code[2*i +: 2] <=
                mem[rd_addr[i][lut_depth_w-1:2]][2*rd_addr[i][1:0] +: 2];
        end
    end

endmodule

// ==== logic/op_sequencer.sv ====
`timescale 1ns/1ps

module op_sequencer
    import epd_pkg::*;
#(
    parameter int init_frames = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  op_req_t                op_req,
    input  logic [5:0]             lut_frames,
    input  logic                   frame_start,
    input  logic [12:0]            h_pix,
    input  logic [11:0]            v_line,
    output logic [pix_per_clk-1:0] in_region,
    output logic [5:0]             auto_fcnt,
    output logic                   init_active
);

    op_req_t    pend;
    logic       pend_valid;
    op_req_t    act;
    logic       act_valid;
    logic [7:0] op_fcnt;
    logic       take_op;

    // Pending copy moves to active only when the frame counter has run out
    assign take_op = frame_start && (op_fcnt == 8'd0) && pend_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid  <= 1'b0;
            act_valid   <= 1'b0;
            init_active <= 1'b1;
            op_fcnt     <= 8'(init_frames);
            auto_fcnt   <= '0;
        end else begin
            if (frame_start) begin
                if (op_fcnt == 8'd0) begin
                    init_active <= 1'b0;
                    act_valid   <= pend_valid;
                    pend_valid  <= 1'b0;
                    if (pend_valid) begin
                        op_fcnt <= (pend.length == 8'd0) ? 8'd0 : pend.length - 8'd1;
                    end
                end else begin
                    op_fcnt <= op_fcnt - 8'd1;
                end
                // Global counter for words in auto view
                if (auto_fcnt == 6'd0) begin
                    auto_fcnt <= lut_frames;
                end else begin
                    auto_fcnt <= auto_fcnt - 6'd1;
                end
            end
            if (op_req.en) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_req.en) begin
            pend <= op_req;
        end
        if (take_op) begin
            act <= pend;
        end
    end

    for (genvar i = 0; i < pix_per_clk; i++) begin : g_lane
        logic [12:0] x;

        assign x = h_pix + 13'(i);
        assign in_region[i] = act_valid &&
            (x >= {1'b0, act.left}) && (x < {1'b0, act.right}) &&
            (v_line >= act.top) && (v_line < act.bottom);
    end

    a_no_req_in_init: assert property (@(posedge clk) disable iff (rst)
        $rose(op_req.en) |-> !init_active);

endmodule

// ==== logic/scan_timing.sv ====
`timescale 1ns/1ps

module scan_timing
    import epd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  epd_timing_t timing,
    input  logic        vin_vsync,
    input  logic        sys_ready,
    input  logic        global_en,
    input  logic        vin_valid,
    input  logic        bi_valid,
    output logic        fetch,
    output logic        frame_start,
    output logic [12:0] h_pix,
    output logic [11:0] v_line,
    output logic        frame_valid,
    output logic        epd_gdclk,
    output logic        epd_gdsp,
    output logic        epd_sdclk,
    output logic        epd_sdle,
    output logic        epd_sdce0
);

    scan_state_e           state;
    logic [cnt_w-1:0]      h_cnt;
    logic [cnt_w-1:0]      v_cnt;
    logic [12:0]           h_ext;
    logic [12:0]           v_ext;
    // Region boundaries, wide enough for the sum of all four fields
    logic [12:0]           hb_start;
    logic [12:0]           ha_start;
    logic [12:0]           htotal;
    logic [12:0]           vb_start;
    logic [12:0]           va_start;
    logic [12:0]           vtotal;
    logic [12:0]           fetch_lo;
    logic [12:0]           fetch_hi;
    logic [12:0]           h_off;
    logic [12:0]           v_off;
    logic                  running;
    logic                  in_vsync;
    logic                  in_vact;
    logic                  in_hfp;
    logic                  in_hsync;
    logic                  in_hbp;
    logic                  in_hact;
    logic                  fetch_d;
    logic [pipe_delay-1:0] act_dly;

    assign h_ext    = {2'b00, h_cnt};
    assign v_ext    = {2'b00, v_cnt};
    assign hb_start = {5'd0, timing.hfp} + {5'd0, timing.hsync};
    assign ha_start = hb_start + {5'd0, timing.hbp};
    assign htotal   = ha_start + {1'b0, timing.hact};
    assign vb_start = {5'd0, timing.vfp} + {5'd0, timing.vsync};
    assign va_start = vb_start + {5'd0, timing.vbp};
    assign vtotal   = va_start + {1'b0, timing.vact};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= scan_idle;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                scan_idle: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && global_en && vin_vsync) begin
                        state <= scan_waiting;
                    end
                end
                scan_waiting: begin
                    if (frame_start) begin
                        state <= scan_running;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + cnt_w'(1);
                    end
                end
                scan_running: begin
                    if (h_ext == htotal - 13'd1) begin
                        h_cnt <= '0;
                        if (v_ext == vtotal - 13'd1) begin
                            state <= scan_idle;
                        end else begin
                            v_cnt <= v_cnt + cnt_w'(1);
                        end
                    end else begin
                        h_cnt <= h_cnt + cnt_w'(1);
                    end
                end
                default: state <= scan_idle;
            endcase
        end
    end

    assign frame_start = (state == scan_waiting) && (h_cnt == cnt_w'(vs_delay));

    // Region flags, only meaningful while running
    assign running  = (state == scan_running);
    assign in_vsync = running && (v_ext >= {5'd0, timing.vfp}) && (v_ext < vb_start);
    assign in_vact  = running && (v_ext >= va_start);
    assign in_hfp   = running && (h_ext < {5'd0, timing.hfp});
    assign in_hsync = running && (h_ext >= {5'd0, timing.hfp}) && (h_ext < hb_start);
    assign in_hbp   = running && (h_ext >= hb_start) && (h_ext < ha_start);
    assign in_hact  = running && (h_ext >= ha_start);

    // Fetch window opens pipe_delay clocks ahead of horizontal active
    assign fetch_lo = ha_start - 13'(pipe_delay);
    assign fetch_hi = htotal - 13'(pipe_delay);
    assign fetch    = in_vact && (h_ext >= fetch_lo) && (h_ext < fetch_hi);

    assign h_off  = h_ext - fetch_lo;
    assign v_off  = v_ext - va_start;
    assign h_pix  = {h_off[10:0], 2'b00};
    assign v_line = v_off[11:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_d     <= 1'b0;
            frame_valid <= 1'b0;
            act_dly     <= '0;
            epd_gdclk   <= 1'b0;
        end else begin
            fetch_d   <= fetch;
            act_dly   <= {act_dly[pipe_delay-2:0], fetch};
            epd_gdclk <= in_hsync || in_hbp || in_hact;
            if (frame_start) begin
                frame_valid <= 1'b1;
            end else if (fetch_d && !vin_valid && !bi_valid) begin
                // Both FIFOs ran dry, mask the rest of the frame
                frame_valid <= 1'b0;
            end
        end
    end

    assign epd_gdsp  = !in_vsync;
    assign epd_sdle  = in_hsync;
    assign epd_sdclk = in_hfp || in_hsync || in_hact;
    assign epd_sdce0 = !act_dly[pipe_delay-1];

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {scan_idle, scan_waiting, scan_running});

    a_no_fetch_idle: assert property (@(posedge clk) disable iff (rst)
        (state == scan_idle) |-> !fetch);

endmodule

// ==== logic/epd_pkg.sv ====
package epd_pkg;

    // Datapath geometry
    localparam int pix_per_clk = 4;
    localparam int cnt_w       = 11;

    // Clocks spent waiting after the input vsync before scanning
    localparam int vs_delay    = 8;
    // Ready leads its output beat by this many clocks
    localparam int pipe_delay  = 3;

    typedef enum logic [1:0] {
        scan_idle    = 2'd0,
        scan_waiting = 2'd1,
        scan_running = 2'd2
    } scan_state_e;

    typedef struct packed {
        logic [7:0]  vfp;
        logic [7:0]  vsync;
        logic [7:0]  vbp;
        logic [11:0] vact;
        logic [7:0]  hfp;
        logic [7:0]  hsync;
        logic [7:0]  hbp;
        logic [11:0] hact;  // counted in clocks, four pixels each
    } epd_timing_t;

    // One byte of the waveform RAM, four 2-bit entries
    typedef struct packed {
        logic        we;
        logic [11:0] addr;
        logic [7:0]  data;
    } lut_wr_t;

    // Region update request, left/right in pixels, top/bottom in lines
    typedef struct packed {
        logic [11:0] left;
        logic [11:0] right;
        logic [11:0] top;
        logic [11:0] bottom;
        logic [7:0]  length;
        logic        en;
    } op_req_t;

    // Per-pixel sequence mode, own frame counter
    typedef struct packed {
        logic       auto;
        logic       unused;
        logic [3:0] src;
        logic [5:0] fcnt;
        logic [3:0] tgt;
    } state_seq_t;

    // Auto sequence mode, frame count comes from the global counter
    typedef struct packed {
        logic       auto;
        logic [6:0] unused;
        logic [3:0] src;
        logic [3:0] tgt;
    } state_auto_t;

    typedef union packed {
        state_seq_t  seq;
        state_auto_t auto;
    } state_word_u;

    typedef struct packed {
        logic [5:0] seq;
        logic [3:0] tgt;
        logic [3:0] src;
    } lut_addr_t;

endpackage
